// ==== rtl/regs_pkg.sv ====
package regs_pkg;

   //////////////////////////////////////////////////
   // Data path widths
   //////////////////////////////////////////////////

   localparam int WORD_W = 16;  // Internal bus width
   localparam int SEL_W  = 3;   // Register select width

   // One register value or one bus word
   typedef logic [WORD_W-1:0] word_t;

   // Selects a register on the write or read side
   typedef logic [SEL_W-1:0] sel_t;

   //////////////////////////////////////////////////
   // Register select codes
   //////////////////////////////////////////////////

   // Same codes on both sides of the bus
   localparam sel_t SEL_A     = 3'd0;  // General register A
   localparam sel_t SEL_B     = 3'd1;  // General register B
   localparam sel_t SEL_X     = 3'd2;  // Index register X
   localparam sel_t SEL_PC    = 3'd3;  // Program counter
   localparam sel_t SEL_FLAGS = 3'd4;  // L and I flags

   // Codes 5 to 7 decode to nothing
   // Writes there are dropped and reads return zero

   //////////////////////////////////////////////////
   // Flags word layout
   //////////////////////////////////////////////////

   // Bit positions of the flags on the bus
   // L is also loaded from this bus bit
   localparam int FLAG_L_BIT = 0;  // Link
   localparam int FLAG_I_BIT = 1;  // Interrupt enable

endpackage

// ==== rtl/gp_reg_bank.sv ====
`timescale 1ns/1ps

module gp_reg_bank
   import regs_pkg::*;
(
   input  logic  latch,   // Register clock, rising edge
   input  logic  arst_n,  // Async reset, active low
   input  logic  wr_en,   // Bus write strobe
   input  sel_t  wr_sel,  // Target of the write
   input  word_t bus_in,  // Write data
   output word_t reg_a,   // Register A contents
   output word_t reg_b,   // Register B contents
   output word_t reg_x    // Register X contents
);

   //////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////

   logic we_a;  // Load strobe for A
   logic we_b;  // Load strobe for B
   logic we_x;  // Load strobe for X

   // PC, flag and unused codes fall through
   assign we_a = wr_en && (wr_sel == SEL_A);
   assign we_b = wr_en && (wr_sel == SEL_B);
   assign we_x = wr_en && (wr_sel == SEL_X);

   //////////////////////////////////////////////////
   // Registers
   //////////////////////////////////////////////////

   always_ff @(posedge latch or negedge arst_n) begin
      if (!arst_n) begin
         reg_a <= '0;
         reg_b <= '0;
         reg_x <= '0;
      end else begin
         if (we_a) begin
            reg_a <= bus_in;  // Load A
         end
         if (we_b) begin
            reg_b <= bus_in;  // Load B
         end
         if (we_x) begin
            reg_x <= bus_in;  // Load X
         end
      end
   end

   // At most one strobe can be high since wr_sel is one code

   // A register that was not addressed keeps its value over the edge
   a_hold_a : assert property (@(posedge latch) disable iff (!arst_n)
      !we_a |=> $stable(reg_a))
      else $error("Register A changed without a write");

   a_hold_b : assert property (@(posedge latch) disable iff (!arst_n)
      !we_b |=> $stable(reg_b))
      else $error("Register B changed without a write");

   a_hold_x : assert property (@(posedge latch) disable iff (!arst_n)
      !we_x |=> $stable(reg_x))
      else $error("Register X changed without a write");

endmodule

// ==== rtl/inc_reg.sv ====
`timescale 1ns/1ps

module inc_reg
   import regs_pkg::*;
(
   input  logic  latch,   // Register clock on the rising edge
   input  logic  arst_n,  // Async reset active low
   input  logic  load,    // Parallel load from d
   input  word_t d,       // Parallel load data
   input  logic  inc,     // Count up by one
   input  logic  dec,     // Count down by one
   output word_t q        // Counter value
);

   //////////////////////////////////////////////////
   // Next value
   //////////////////////////////////////////////////

   word_t q_up;   // q + 1 wrapping at 0xFFFF
   word_t q_dn;   // q - 1 wrapping at 0
   word_t q_nxt;  // Value taken at the next edge

   // Both wrap naturally in 16 bits
   assign q_up = q + word_t'(1);
   assign q_dn = q - word_t'(1);

   always_comb begin
      if (load) begin
         q_nxt = d;       // Load wins over counting
      end else if (inc) begin
         q_nxt = q_up;
      end else if (dec) begin
         q_nxt = q_dn;
      end else begin
         q_nxt = q;       // Hold
      end
   end

   //////////////////////////////////////////////////
   // Counter register
   //////////////////////////////////////////////////

   // Replaces the chain of up/down counter chips
   // Carry and borrow ripple is just the adder here
   always_ff @(posedge latch or negedge arst_n) begin
      if (!arst_n) begin
         q <= '0;
      end else begin
         q <= q_nxt;
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   // Control unit must never ask for both directions at once
   a_inc_dec_excl : assert property (@(posedge latch) disable iff (!arst_n)
      !(inc && dec))
      else $error("PC inc and dec high in the same cycle");

endmodule

// ==== rtl/flag_bits.sv ====
`timescale 1ns/1ps

module flag_bits (
   input  logic latch,         // Register clock, rising edge
   input  logic arst_n,        // Async reset, active low
   input  logic l_load,        // Load L from l_d
   input  logic l_d,           // Load data for L
   input  logic l_toggle_alu,  // Flip L, ALU side
   input  logic l_toggle_ctl,  // Flip L, control side
   input  logic l_clear,       // Clear L
   input  logic i_toggle,      // Flip I
   input  logic i_clear,       // Clear I
   output logic l_q,           // Link flag
   output logic i_q            // Interrupt enable flag
);

   //////////////////////////////////////////////////
   // Link flag
   //////////////////////////////////////////////////

   logic l_toggle;  // Either toggle source
   logic l_nxt;     // L after the edge
   logic i_nxt;     // I after the edge

   // Two toggles in one cycle still flip only once
   assign l_toggle = l_toggle_alu | l_toggle_ctl;

   always_comb begin
      if (l_clear) begin
         l_nxt = 1'b0;     // Clear beats everything
      end else if (l_toggle) begin
         l_nxt = ~l_q;     // Toggle beats load
      end else if (l_load) begin
         l_nxt = l_d;
      end else begin
         l_nxt = l_q;
      end
   end

   //////////////////////////////////////////////////
   // Interrupt enable flag
   //////////////////////////////////////////////////

   // Clear beats toggle
   assign i_nxt = i_clear ? 1'b0 : (i_q ^ i_toggle);

   // J-K flip-flop pair collapses to two D bits
   always_ff @(posedge latch or negedge arst_n) begin
      if (!arst_n) begin
         l_q <= 1'b0;
         i_q <= 1'b0;
      end else begin
         l_q <= l_nxt;
         i_q <= i_nxt;
      end
   end

   // A clear always leaves L low, whatever else came with it
   a_l_clear : assert property (@(posedge latch) disable iff (!arst_n)
      l_clear |=> !l_q)
      else $error("L not zero after l_clear");

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
   import regs_pkg::*;
(
   input  logic  latch,         // Register clock, rising edge
   input  logic  arst_n,        // Async reset, active low
   // Write side
   input  logic  wr_en,         // Bus write strobe
   input  sel_t  wr_sel,        // Write target
   input  word_t bus_in,        // Write data from the bus
   // Read side
   input  sel_t  rd_sel,        // Register driven onto bus_out
   output word_t bus_out,       // Selected register
   // PC counting
   input  logic  pc_inc,        // PC + 1
   input  logic  pc_dec,        // PC - 1
   // Flag control
   input  logic  l_toggle_alu,  // Flip L from the ALU
   input  logic  l_toggle_ctl,  // Flip L from the control unit
   input  logic  l_clear,       // Clear L
   input  logic  i_toggle,      // Flip I
   input  logic  i_clear,       // Clear I
   // Front panel
   output word_t con_a,         // A for the console
   output word_t con_b,         // B for the console
   output word_t con_x,         // X for the console
   output word_t con_pc,        // PC for the console
   output logic  l_flag,        // Link flag
   output logic  i_flag         // Interrupt enable
);

   //////////////////////////////////////////////////
   // Write strobes for PC and L
   //////////////////////////////////////////////////

   logic  pc_load;     // Bus write to the PC
   logic  l_load;      // Bus write to the flags
   word_t flags_word;  // Flags as seen on the read bus

   assign pc_load = wr_en && (wr_sel == SEL_PC);
   assign l_load  = wr_en && (wr_sel == SEL_FLAGS);

   //////////////////////////////////////////////////
   // Sub-blocks
   //////////////////////////////////////////////////

   // A, B and X decode their own codes
   gp_reg_bank u_gp (
      .latch  (latch),
      .arst_n (arst_n),
      .wr_en  (wr_en),
      .wr_sel (wr_sel),
      .bus_in (bus_in),
      .reg_a  (con_a),
      .reg_b  (con_b),
      .reg_x  (con_x)
   );

   inc_reg u_pc (
      .latch  (latch),
      .arst_n (arst_n),
      .load   (pc_load),
      .d      (bus_in),
      .inc    (pc_inc),
      .dec    (pc_dec),
      .q      (con_pc)
   );

   // Only L is writable from the bus and I has no load path
   flag_bits u_flags (
      .latch        (latch),
      .arst_n       (arst_n),
      .l_load       (l_load),
      .l_d          (bus_in[FLAG_L_BIT]),
      .l_toggle_alu (l_toggle_alu),
      .l_toggle_ctl (l_toggle_ctl),
      .l_clear      (l_clear),
      .i_toggle     (i_toggle),
      .i_clear      (i_clear),
      .l_q          (l_flag),
      .i_q          (i_flag)
   );

   //////////////////////////////////////////////////
   // Read bus
   //////////////////////////////////////////////////

   always_comb begin
      flags_word             = '0;  // Upper bits read zero
      flags_word[FLAG_L_BIT] = l_flag;
      flags_word[FLAG_I_BIT] = i_flag;
   end

   // Takes the place of the tri-state buffers and their enables
   always_comb begin
      case (rd_sel)
         SEL_A:     bus_out = con_a;
         SEL_B:     bus_out = con_b;
         SEL_X:     bus_out = con_x;
         SEL_PC:    bus_out = con_pc;
         SEL_FLAGS: bus_out = flags_word;
         default:   bus_out = '0;   // Unused codes
      endcase
   end

endmodule

// ==== tb/reg_file_tb.sv ====
`timescale 1ns/1ps

module reg_file_tb
   import regs_pkg::*;
;

   localparam int RESET_CYC = 3;     // Cycles with arst_n low
   localparam int DIR_CYC   = 40;    // Directed part rounded up
   localparam int RAND_CYC  = 400;   // Random part
   // About a third on top of the expected run length
   localparam int LIMIT_CYC = (RESET_CYC + DIR_CYC + RAND_CYC) * 4 / 3 + 10;
   localparam logic [31:0] SEED = 32'd55983;

   // Model state with one field per architectural register
   typedef struct packed {
      word_t a;
      word_t b;
      word_t x;
      word_t pc;
      logic  l;
      logic  i;
   } model_t;

   logic  latch, arst_n, wr_en, pc_inc, pc_dec;
   logic  l_toggle_alu, l_toggle_ctl, l_clear, i_toggle, i_clear;
   sel_t  wr_sel, rd_sel;
   word_t bus_in, bus_out, con_a, con_b, con_x, con_pc;
   logic  l_flag, i_flag;
   model_t model, nxt;     // Present and next model state
   int    err_cnt = 0;
   int    cyc_cnt = 0;

   reg_file dut0 (.*);

   always #50 latch = ~latch;  // 100 ns period

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic model_t step_ref(input model_t s, input logic we, input sel_t ws,
                                       input word_t din, input logic inc, input logic dec,
                                       input logic tal, input logic tct, input logic lclr,
                                       input logic itog, input logic iclr);
      model_t n;
      n = s;
      if (we && ws == SEL_A) n.a = din;
      if (we && ws == SEL_B) n.b = din;
      if (we && ws == SEL_X) n.x = din;
      if (we && ws == SEL_PC) n.pc = din;           // Load beats counting
      else if (inc)           n.pc = s.pc + 16'd1;  // Wraps at 0xFFFF
      else if (dec)           n.pc = s.pc - 16'd1;  // Wraps at 0
      if (lclr)                     n.l = 1'b0;
      else if (tal || tct)          n.l = ~s.l;     // One flip for both
      else if (we && ws == SEL_FLAGS) n.l = din[FLAG_L_BIT];
      if (iclr)      n.i = 1'b0;
      else if (itog) n.i = ~s.i;
      return n;
   endfunction

   // Expected read bus for one select code
   function automatic word_t read_ref(input model_t s, input sel_t sel);
      word_t r;
      r = '0;
      case (sel)
         SEL_A:  r = s.a;
         SEL_B:  r = s.b;
         SEL_X:  r = s.x;
         SEL_PC: r = s.pc;
         SEL_FLAGS: begin
            r[FLAG_L_BIT] = s.l;
            r[FLAG_I_BIT] = s.i;
         end
         default: r = '0;  // Unused codes
      endcase
      return r;
   endfunction

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_val(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         err_cnt++;
         $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
         $display("*** FAILED ***");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   //////////////////////////////////////////////////
   // Comparison
   //////////////////////////////////////////////////

   initial begin : compare
      model = '0;
      forever begin
         @(negedge latch);
         #40;  // Inputs settled just before the rising edge
         check_val("bus_out", bus_out, read_ref(model, rd_sel));  // Old contents
         if (arst_n) begin
            nxt = step_ref(model, wr_en, wr_sel, bus_in, pc_inc, pc_dec,
                           l_toggle_alu, l_toggle_ctl, l_clear, i_toggle, i_clear);
         end else begin
            nxt = '0;
         end
         @(posedge latch);
         #10;
         model = nxt;
         check_val("con_a", con_a, model.a);
         check_val("con_b", con_b, model.b);
         check_val("con_x", con_x, model.x);
         check_val("con_pc", con_pc, model.pc);
         check_val("l_flag", word_t'(l_flag), word_t'(model.l));
         check_val("i_flag", word_t'(i_flag), word_t'(model.i));
      end
   end

   // Hang guard
   always @(posedge latch) begin
      cyc_cnt++;
      if (cyc_cnt >= LIMIT_CYC) begin
         $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYC);
         $display("*** FAILED ***");
         $fatal(1, "Cycle limit reached");
      end
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   // Advance one cycle and drop the strobes back to idle
   task automatic next_cycle();
      @(negedge latch);
      wr_en = 1'b0;
      pc_inc = 1'b0;
      pc_dec = 1'b0;
      l_toggle_alu = 1'b0;
      l_toggle_ctl = 1'b0;
      l_clear = 1'b0;
      i_toggle = 1'b0;
      i_clear = 1'b0;
   endtask

   task automatic write_reg(input sel_t sel, input word_t val);
      wr_en = 1'b1;
      wr_sel = sel;
      bus_in = val;
   endtask

   initial begin : stim
      int k;
      logic [31:0] rnd;
      latch = 1'b0;
      arst_n = 1'b0;
      wr_en = 1'b0;
      wr_sel = SEL_A;
      bus_in = '0;
      rd_sel = SEL_A;
      pc_inc = 1'b0;
      pc_dec = 1'b0;
      l_toggle_alu = 1'b0;
      l_toggle_ctl = 1'b0;
      l_clear = 1'b0;
      i_toggle = 1'b0;
      i_clear = 1'b0;
      repeat (RESET_CYC) @(negedge latch);
      arst_n = 1'b1;

      for (k = 0; k < 8; k++) begin  // Every read code is zero after reset
         rd_sel = sel_t'(k);
         next_cycle();
      end

      rd_sel = SEL_A;
      write_reg(SEL_A, 16'h1234);  // Bus still shows the old A
      next_cycle();
      write_reg(SEL_B, 16'hBEEF);  // New A on the bus
      next_cycle();
      rd_sel = SEL_B;              // New B on the bus
      write_reg(SEL_X, 16'h0F0F);
      next_cycle();
      rd_sel = SEL_X;              // New X on the bus
      next_cycle();
      for (k = 5; k < 8; k++) begin  // Unused codes have no effect
         rd_sel = sel_t'(k);
         write_reg(sel_t'(k), 16'hFFFF);
         next_cycle();
      end

      rd_sel = SEL_PC;
      write_reg(SEL_PC, 16'hFFFE);
      next_cycle();
      pc_inc = 1'b1;
      next_cycle();
      pc_inc = 1'b1;   // Wraps to 0
      next_cycle();
      pc_dec = 1'b1;   // Back to 0xFFFF
      next_cycle();
      write_reg(SEL_PC, 16'h0001);  // Load wins
      pc_inc = 1'b1;
      next_cycle();
      pc_dec = 1'b1;
      next_cycle();
      pc_dec = 1'b1;
      next_cycle();

      // L flag
      rd_sel = SEL_FLAGS;
      write_reg(SEL_FLAGS, 16'hFFFF);  // L from bit 0
      next_cycle();
      l_toggle_alu = 1'b1;
      next_cycle();
      l_toggle_ctl = 1'b1;
      next_cycle();
      l_toggle_alu = 1'b1;
      l_toggle_ctl = 1'b1;
      next_cycle();
      write_reg(SEL_FLAGS, 16'h0000);  // Toggle over load
      l_toggle_alu = 1'b1;
      next_cycle();
      write_reg(SEL_FLAGS, 16'hFFFE);  // L back to 0
      next_cycle();
      write_reg(SEL_FLAGS, 16'h0001);  // Load or toggle alone would set L
      l_toggle_ctl = 1'b1;
      l_clear = 1'b1;
      next_cycle();

      // I flag
      i_toggle = 1'b1;
      next_cycle();
      i_clear = 1'b1;
      next_cycle();
      i_toggle = 1'b1;   // Clear keeps I at 0
      i_clear = 1'b1;
      next_cycle();
      i_toggle = 1'b1;
      l_toggle_alu = 1'b1;
      next_cycle();
      next_cycle();  // Both bits set on the bus

      rnd = SEED;
      repeat (RAND_CYC) begin
         rnd = lcg_next(rnd);
         wr_en = rnd[31];
         wr_sel = rnd[30:28];
         rd_sel = rnd[27:25];
         pc_inc = rnd[24] & rnd[23];
         pc_dec = rnd[22] & rnd[21] & ~pc_inc;  // Never both
         l_toggle_alu = rnd[20] & rnd[19];
         l_toggle_ctl = rnd[18] & rnd[17];
         l_clear = rnd[16] & rnd[15] & rnd[14];
         i_toggle = rnd[13] & rnd[12];
         i_clear = rnd[11] & rnd[10] & rnd[9];
         rnd = lcg_next(rnd);
         bus_in = rnd[31:16];
         next_cycle();
      end
      next_cycle();

      if (err_cnt == 0) begin
         $display("*** PASSED ***");
         $finish;
      end else begin
         $display("*** FAILED ***");
         $fatal(1, "Errors were found");
      end
   end

endmodule

// ==== filelist.f ====
rtl/regs_pkg.sv
rtl/gp_reg_bank.sv
rtl/inc_reg.sv
rtl/flag_bits.sv
rtl/reg_file.sv
tb/reg_file_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register file testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   -f filelist.f \
   --top-module reg_file_tb \
   -o sim_reg_file

# The simulator exit status is not used; the log decides
./obj_dir/sim_reg_file 2>&1 | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
   echo "Simulation failed"
   exit 1
fi

if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi

echo "Simulation passed"
